// ==== cpu_axi_bridge.f ====
+incdir+include
source/sched_cpu_pkg.sv
source/cpu_read_path.sv
source/cpu_write_path.sv
source/cpu_axi_bridge.sv
sim/cpu_axi_bridge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the bridge testbench with verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_axi_bridge_tb -Mdir obj_dir -f cpu_axi_bridge.f \
    && ./obj_dir/Vcpu_axi_bridge_tb > sim.log 2>&1 \
    || echo "simulation build or run did not complete"

cat sim.log 2>/dev/null

grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim/cpu_axi_bridge_cases.txt ====
# name op port kind index offset data expect resp req (index, data and expect in hex)
# kind 0 pkt, 1 sume, 2 pifo, 3 calendar; data is wdata on writes, buffer value on reads
pifo_wr_p0    wr 0 2 005 0 1234abcd 1234abcd 0 1
cal_wr_p4     wr 4 3 fff 0 cafef00d cafef00d 0 1
sume_wr_b0    wr 2 1 123 0 11111111 0 0 0
sume_wr_b1    wr 2 1 123 0 22222222 0 0 0
sume_wr_b2    wr 2 1 123 0 33333333 0 0 0
sume_wr_b3    wr 2 1 123 0 44444444 11111111222222223333333344444444 0 1
pifo_rd_p1    rd 1 2 042 0 aaaaaaaabbbbbbbbcccccccc9abcdef0 9abcdef0 0 1
cal_rd_p3     rd 3 3 7ff 0 0123456789abcdef0fedcba987654321 87654321 0 1
sume_rd_w0    rd 0 1 100 0 11112222333344445555666677778888 77778888 0 1
sume_rd_w1    rd 2 1 100 1 11112222333344445555666677778888 55556666 0 1
sume_rd_w2    rd 0 1 100 2 11112222333344445555666677778888 33334444 0 1
sume_rd_w3    rd 4 1 abc 3 11112222333344445555666677778888 11112222 0 1
pkt_rd        rd 0 0 001 0 ffffffff 0 3 0
pkt_wr        wr 1 0 001 0 5a5a5a5a 0 3 0
port5_rd      rd 5 2 010 0 ffffffff 0 3 0
port7_wr      wr 7 3 010 0 5a5a5a5a 0 3 0
sume_rd_off4  rd 1 1 020 4 11112222333344445555666677778888 0 3 0
sume_rd_off9  rd 1 1 020 9 11112222333344445555666677778888 0 3 0
sume_cut_b0   wr 3 1 055 0 a1a1a1a1 0 0 0
sume_cut_b1   wr 3 1 055 0 b2b2b2b2 0 0 0
pifo_in_sume  wr 3 2 055 0 0badf00d 0 3 0
sume_new_b0   wr 3 1 055 0 c3c3c3c3 0 0 0
sume_new_b1   wr 3 1 055 0 d4d4d4d4 0 0 0
sume_new_b2   wr 3 1 055 0 e5e5e5e5 0 0 0
sume_new_b3   wr 3 1 055 0 f6f6f6f6 c3c3c3c3d4d4d4d4e5e5e5e5f6f6f6f6 0 1
pifo_wr_after wr 0 2 006 0 87654321 87654321 0 1

// ==== include/cpu_axi_bridge_tb_checks.svh ====
`ifndef CPU_AXI_BRIDGE_TB_CHECKS_SVH
`define CPU_AXI_BRIDGE_TB_CHECKS_SVH

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
        $display("Mismatch %s: expected %b, actual %b", name, exp, act);
        mismatch_count++;
    end
endtask

task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp)
    begin
        $display("Mismatch %s resp: expected %0d, actual %0d", name, exp, act);
        mismatch_count++;
    end
endtask

task automatic check_rdata(input string name, input logic [axi_data_width-1:0] exp,
                           input logic [axi_data_width-1:0] act);
    if (act !== exp)
    begin
        $display("Mismatch %s rdata: expected %h, actual %h", name, exp, act);
        mismatch_count++;
    end
endtask

task automatic check_rd_req(input string name, input buf_rd_req_t exp, input buf_rd_req_t act);
    if (act !== exp)
    begin
        $display("Mismatch %s rd_req: expected %h, actual %h", name, exp, act);
        mismatch_count++;
    end
endtask

task automatic check_wr_req(input string name, input buf_wr_req_t exp, input buf_wr_req_t act);
    if (act !== exp)
    begin
        $display("Mismatch %s wr_req: expected %h, actual %h", name, exp, act);
        mismatch_count++;
    end
endtask

//////////////////////////////////////////////////
// bounded waits
//////////////////////////////////////////////////

typedef enum int
{
    watch_arready,
    watch_aw_w_ready,
    watch_rvalid,
    watch_bvalid
} watch_e;

function automatic logic signal_high(input watch_e sel);
    case (sel)
        watch_arready:    return s_axi_arready;
        watch_aw_w_ready: return s_axi_awready && s_axi_wready;
        watch_rvalid:     return s_axi_rvalid;
        default:          return s_axi_bvalid;
    endcase
endfunction

// looks at the current falling edge first, then walks forward
task automatic wait_until_high(input watch_e sel, input string what);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = (signal_high(sel) === 1'b1);
    while (!seen && (cycles < wait_limit))
    begin
        @(negedge S_AXI_ACLK);
        cycles++;
        seen = (signal_high(sel) === 1'b1);
    end
    if (!seen)
    begin
        $display("Timeout: %s did not go high within %0d cycles", what, wait_limit);
        timeout_count++;
    end
endtask

`endif

// ==== sim/cpu_axi_bridge_tb.sv ====
`timescale 1ns/1ns

module cpu_axi_bridge_tb;

    import sched_cpu_pkg::*;

    logic                      S_AXI_ACLK;
    logic                      S_AXI_ARESETN;

    // aw, w and b channels
    logic                      s_axi_awvalid;
    logic                      s_axi_awready;
    logic [axi_addr_width-1:0] s_axi_awaddr;
    logic                      s_axi_wvalid;
    logic                      s_axi_wready;
    logic [axi_data_width-1:0] s_axi_wdata;
    logic                      s_axi_bvalid;
    logic                      s_axi_bready;
    logic [1:0]                s_axi_bresp;

    // ar and r channels
    logic                      s_axi_arvalid;
    logic                      s_axi_arready;
    logic [axi_addr_width-1:0] s_axi_araddr;
    logic                      s_axi_rvalid;
    logic                      s_axi_rready;
    logic [axi_data_width-1:0] s_axi_rdata;
    logic [1:0]                s_axi_rresp;

    buf_rd_req_t               buf_rd_req;
    buf_rd_resp_t              buf_rd_resp;
    buf_wr_req_t               buf_wr_req;
    logic                      buf_wr_ack;

    int seed           = 23260;
    int wait_limit     = 100;
    int mismatch_count = 0;
    int timeout_count  = 0;
    int other_count    = 0;
    int case_count     = 0;

    // what the buffer model has seen
    int                    rd_req_count = 0;
    int                    wr_req_count = 0;
    buf_rd_req_t           last_rd_req;
    buf_wr_req_t           last_wr_req;
    logic [sume_width-1:0] resp_value;

    `include "cpu_axi_bridge_tb_checks.svh"

    cpu_axi_bridge i_dut
    (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awprot  (3'b000),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (4'hf),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arprot  (3'b000),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .buf_rd_req    (buf_rd_req),
        .buf_rd_resp   (buf_rd_resp),
        .buf_wr_req    (buf_wr_req),
        .buf_wr_ack    (buf_wr_ack)
    );

    initial
    begin
        S_AXI_ACLK = 1'b0;
        forever
        begin
            #10 S_AXI_ACLK = ~S_AXI_ACLK;
        end
    end

    function automatic int pick_delay(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    //////////////////////////////////////////////////
    // buffer model
    //////////////////////////////////////////////////

    // one access in flight at a time, so one process serves both directions
    initial
    begin : responder
        int   delay;
        logic is_read;
        buf_rd_resp = '0;
        buf_wr_ack  = 1'b0;
        forever
        begin
            @(negedge S_AXI_ACLK);
            if ((buf_rd_req.port_valid != '0) || (buf_wr_req.port_valid != '0))
            begin
                is_read = (buf_rd_req.port_valid != '0);
                if (is_read)
                begin
                    rd_req_count++;
                    last_rd_req = buf_rd_req;
                end
                else
                begin
                    wr_req_count++;
                    last_wr_req = buf_wr_req;
                end
                delay = pick_delay(1, 4);
                repeat (delay) @(negedge S_AXI_ACLK);
                buf_rd_resp = '{valid: is_read, value: resp_value};
                buf_wr_ack  = !is_read;
                @(negedge S_AXI_ACLK);
                buf_rd_resp.valid = 1'b0;
                buf_wr_ack        = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // one access from the case file
    //////////////////////////////////////////////////

    task automatic run_case(input logic is_read, input string name, input cpu_addr_t addr,
                            input logic [sume_width-1:0] data,
                            input logic [sume_width-1:0] exp_value,
                            input logic [1:0] exp_resp, input logic exp_req);
        int          rd_before;
        int          wr_before;
        int          stall;
        buf_rd_req_t exp_rd;
        buf_wr_req_t exp_wr;
        rd_before  = rd_req_count;
        wr_before  = wr_req_count;
        resp_value = data;
        exp_rd     = '{kind: addr.kind, port_valid: port_num'(1) << addr.port, index: addr.index};
        exp_wr     = '{kind: addr.kind, port_valid: exp_rd.port_valid, index: addr.index,
                       value: exp_value};
        if (is_read)
        begin
            s_axi_araddr  = addr;
            s_axi_arvalid = 1'b1;
            wait_until_high(watch_arready, {name, " arready"});
        end
        else
        begin
            s_axi_awaddr  = addr;
            s_axi_wdata   = data[axi_data_width-1:0];
            s_axi_awvalid = 1'b1;
            s_axi_wvalid  = 1'b1;
            wait_until_high(watch_aw_w_ready, {name, " awready and wready"});
        end
        @(negedge S_AXI_ACLK);
        s_axi_arvalid = 1'b0;
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        wait_until_high(is_read ? watch_rvalid : watch_bvalid, {name, " response"});

        // master stalls, response holds and nothing new gets in
        stall = pick_delay(0, 3);
        repeat (stall)
        begin
            @(negedge S_AXI_ACLK);
            check_flag({name, " valid held"}, 1'b1, is_read ? s_axi_rvalid : s_axi_bvalid);
            check_flag({name, " accept blocked"}, 1'b0, is_read ? s_axi_arready : s_axi_awready);
        end
        if (is_read)
        begin
            check_rdata(name, exp_value[axi_data_width-1:0], s_axi_rdata);
            check_resp(name, exp_resp, s_axi_rresp);
            s_axi_rready = 1'b1;
        end
        else
        begin
            check_resp(name, exp_resp, s_axi_bresp);
            s_axi_bready = 1'b1;
        end
        @(negedge S_AXI_ACLK);
        s_axi_rready = 1'b0;
        s_axi_bready = 1'b0;
        check_flag({name, " delivered once"}, 1'b0, is_read ? s_axi_rvalid : s_axi_bvalid);

        if (((rd_req_count - rd_before) != ((is_read && exp_req) ? 1 : 0)) ||
            ((wr_req_count - wr_before) != ((!is_read && exp_req) ? 1 : 0)))
        begin
            $display("Wrong number of buffer requests in %s: %0d reads, %0d writes",
                     name, rd_req_count - rd_before, wr_req_count - wr_before);
            other_count++;
        end
        else if (exp_req && is_read)
            check_rd_req(name, exp_rd, last_rd_req);
        else if (exp_req)
            check_wr_req(name, exp_wr, last_wr_req);
    endtask

    initial
    begin : main
        int                     fd;
        int                     n;
        int                     port;
        int                     kind;
        int                     offset;
        int                     resp;
        int                     req;
        string                  line;
        string                  name;
        string                  op;
        logic [index_width-1:0] index;
        logic [sume_width-1:0]  data;
        logic [sume_width-1:0]  exp_value;
        cpu_addr_t              addr;
        S_AXI_ARESETN = 1'b0;
        s_axi_awvalid = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_wdata   = '0;
        s_axi_bready  = 1'b0;
        s_axi_arvalid = 1'b0;
        s_axi_araddr  = '0;
        s_axi_rready  = 1'b0;
        repeat (3) @(posedge S_AXI_ACLK);
        @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;
        @(negedge S_AXI_ACLK);

        // idle after reset
        check_flag("reset arready", 1'b1, s_axi_arready);
        check_flag("reset awready", 1'b1, s_axi_awready);
        check_flag("reset wready", 1'b1, s_axi_wready);
        check_flag("reset rvalid", 1'b0, s_axi_rvalid);
        check_flag("reset bvalid", 1'b0, s_axi_bvalid);
        check_flag("reset rd_req valid", 1'b0, buf_rd_req.port_valid != '0);
        check_flag("reset wr_req valid", 1'b0, buf_wr_req.port_valid != '0);

        fd = $fopen("sim/cpu_axi_bridge_cases.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the case file");
            other_count++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n    = $fgets(line, fd);
                if ((line.len() > 1) && (line.substr(0, 0) != "#"))
                begin
                    n = $sscanf(line, "%s %s %d %d %h %d %h %h %d %d", name, op, port,
                                kind, index, offset, data, exp_value, resp, req);
                    if (n != 10)
                    begin
                        $display("Case line could not be parsed: %s", line);
                        other_count++;
                    end
                    else
                    begin
                        addr = '{is_state: 1'b0, port: port[2:0], kind: buf_kind_e'(kind[1:0]),
                                 index: index, offset: offset[3:0]};
                        case_count++;
                        run_case(op == "rd", name, addr, data, exp_value, resp[1:0], req[0]);
                    end
                end
            end
            $fclose(fd);
        end
        if (case_count == 0)
        begin
            $display("No cases were run");
            other_count++;
        end

        $display("cases %0d, mismatches %0d, timeouts %0d, other failures %0d",
                 case_count, mismatch_count, timeout_count, other_count);
        if ((mismatch_count + timeout_count + other_count) == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== source/cpu_axi_bridge.sv ====
`timescale 1ns/1ns

module cpu_axi_bridge
(
    input  logic                                     S_AXI_ACLK,
    input  logic                                     S_AXI_ARESETN,

    // aw channel
    input  logic                                     s_axi_awvalid,
    output logic                                     s_axi_awready,
    input  logic [sched_cpu_pkg::axi_addr_width-1:0] s_axi_awaddr,
    input  logic [2:0]                               s_axi_awprot,

    // w channel
    input  logic                                     s_axi_wvalid,
    output logic                                     s_axi_wready,
    input  logic [sched_cpu_pkg::axi_data_width-1:0] s_axi_wdata,
    input  logic [sched_cpu_pkg::axi_data_width/8-1:0] s_axi_wstrb,

    // b channel
    output logic                                     s_axi_bvalid,
    input  logic                                     s_axi_bready,
    output logic [1:0]                               s_axi_bresp,

    // ar channel
    input  logic                                     s_axi_arvalid,
    output logic                                     s_axi_arready,
    input  logic [sched_cpu_pkg::axi_addr_width-1:0] s_axi_araddr,
    input  logic [2:0]                               s_axi_arprot,

    // r channel
    output logic                                     s_axi_rvalid,
    input  logic                                     s_axi_rready,
    output logic [sched_cpu_pkg::axi_data_width-1:0] s_axi_rdata,
    output logic [1:0]                               s_axi_rresp,

    // scheduler buffers
    output sched_cpu_pkg::buf_rd_req_t               buf_rd_req,
    input  sched_cpu_pkg::buf_rd_resp_t              buf_rd_resp,
    output sched_cpu_pkg::buf_wr_req_t               buf_wr_req,
    input  logic                                     buf_wr_ack
);

    import sched_cpu_pkg::*;

    // byte strobes and protection bits carry no meaning for these registers

    cpu_read_path i_read_path
    (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .arvalid       (s_axi_arvalid),
        .arready       (s_axi_arready),
        .araddr        (cpu_addr_t'(s_axi_araddr)),
        .rvalid        (s_axi_rvalid),
        .rready        (s_axi_rready),
        .rdata         (s_axi_rdata),
        .rresp         (s_axi_rresp),
        .rd_req        (buf_rd_req),
        .rd_resp       (buf_rd_resp)
    );

    cpu_write_path i_write_path
    (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .awvalid       (s_axi_awvalid),
        .awready       (s_axi_awready),
        .awaddr        (cpu_addr_t'(s_axi_awaddr)),
        .wvalid        (s_axi_wvalid),
        .wready        (s_axi_wready),
        .wdata         (s_axi_wdata),
        .bvalid        (s_axi_bvalid),
        .bready        (s_axi_bready),
        .bresp         (s_axi_bresp),
        .wr_req        (buf_wr_req),
        .wr_ack        (buf_wr_ack)
    );

endmodule

// ==== source/cpu_read_path.sv ====
`timescale 1ns/1ns

module cpu_read_path
(
    input  logic                                     S_AXI_ACLK,
    input  logic                                     S_AXI_ARESETN,
    // ar channel
    input  logic                                     arvalid,
    output logic                                     arready,
    input  sched_cpu_pkg::cpu_addr_t                 araddr,
    // r channel
    output logic                                     rvalid,
    input  logic                                     rready,
    output logic [sched_cpu_pkg::axi_data_width-1:0] rdata,
    output logic [1:0]                               rresp,
    // buffer side
    output sched_cpu_pkg::buf_rd_req_t               rd_req,
    input  sched_cpu_pkg::buf_rd_resp_t              rd_resp
);

    import sched_cpu_pkg::*;

    typedef enum logic [1:0]
    {
        rd_idle,
        rd_await_resp,
        rd_respond
    } rd_state_e;

    rd_state_e                 state_q;
    cpu_addr_t                 addr_q;
    logic [port_num-1:0]       req_valid_q;
    logic                      ar_accept;
    logic                      ar_ok;
    logic [axi_data_width-1:0] resp_word;

    // one read in flight at a time
    assign arready   = (state_q == rd_idle);
    assign ar_accept = arvalid && arready;

    // sume offsets past the last word are rejected
    assign ar_ok = port_kind_ok(araddr) &&
                   !((araddr.kind == sume_buffer) && (araddr.offset >= sume_word_count));

    // kind and index come from the latched address
    assign rd_req = '{kind: addr_q.kind, port_valid: req_valid_q, index: addr_q.index};

    //////////////////////////////////////////////////
    // word select
    //////////////////////////////////////////////////

    always_comb
    begin
        if (addr_q.kind == sume_buffer)
        begin
            // word 0 is the least significant
            resp_word = rd_resp.value[addr_q.offset[sume_cnt_width-1:0]*axi_data_width +:
                                      axi_data_width];
        end
        else
        begin
            resp_word = rd_resp.value[pifo_width-1:0];
        end
    end

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            state_q     <= rd_idle;
            req_valid_q <= '0;
            rvalid      <= 1'b0;
        end
        else
        begin
            // request is a single-cycle pulse
            req_valid_q <= '0;
            case (state_q)
                rd_idle:
                    if (ar_accept)
                    begin
                        if (ar_ok)
                        begin
                            req_valid_q <= port_onehot(araddr.port);
                            state_q     <= rd_await_resp;
                        end
                        else
                        begin
                            rvalid  <= 1'b1;
                            state_q <= rd_respond;
                        end
                    end
                rd_await_resp:
                    if (rd_resp.valid)
                    begin
                        rvalid  <= 1'b1;
                        state_q <= rd_respond;
                    end
                rd_respond:
                    if (rready)
                    begin
                        rvalid  <= 1'b0;
                        state_q <= rd_idle;
                    end
                default:
                    state_q <= rd_idle;
            endcase
        end
    end

    // address and r payload
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (ar_accept)
        begin
            addr_q <= araddr;
            if (!ar_ok)
            begin
                rdata <= '0;
                rresp <= resp_decerr;
            end
        end
        else if ((state_q == rd_await_resp) && rd_resp.valid)
        begin
            rdata <= resp_word;
            rresp <= resp_okay;
        end
    end

    // buffer request pulses for one cycle on a single port
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (rd_req.port_valid != '0) |->
            $onehot(rd_req.port_valid) && ($past(rd_req.port_valid) == '0));

    // r beat held until the master takes it
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)));

endmodule

// ==== source/cpu_write_path.sv ====
`timescale 1ns/1ns

module cpu_write_path
(
    input  logic                                     S_AXI_ACLK,
    input  logic                                     S_AXI_ARESETN,
    // aw channel
    input  logic                                     awvalid,
    output logic                                     awready,
    input  sched_cpu_pkg::cpu_addr_t                 awaddr,
    // w channel
    input  logic                                     wvalid,
    output logic                                     wready,
    input  logic [sched_cpu_pkg::axi_data_width-1:0] wdata,
    // b channel
    output logic                                     bvalid,
    input  logic                                     bready,
    output logic [1:0]                               bresp,
    // buffer side
    output sched_cpu_pkg::buf_wr_req_t               wr_req,
    input  logic                                     wr_ack
);

    import sched_cpu_pkg::*;

    typedef enum logic [1:0]
    {
        wr_idle,
        wr_collect,
        wr_await_ack,
        wr_respond
    } wr_state_e;

    wr_state_e                 state_q;
    logic [sume_cnt_width-1:0] sume_cnt_q;
    logic [sume_width-1:0]     assembly_q;
    logic [sume_width-1:0]     sume_next;

    // request registers
    logic [port_num-1:0]       wr_valid_q;
    buf_kind_e                 wr_kind_q;
    logic [index_width-1:0]    wr_index_q;
    logic [sume_width-1:0]     wr_value_q;

    logic                      accept_ok;
    logic                      beat_accept;
    logic                      beat_bad;
    logic                      is_sume;
    logic                      last_beat;

    // request seen on the buffer port and not yet acknowledged
    logic                      ack_pending_q;

    //////////////////////////////////////////////////
    // beat decode
    //////////////////////////////////////////////////

    // aw and w are taken together, never one alone
    assign accept_ok   = (state_q == wr_idle) || (state_q == wr_collect);
    assign awready     = accept_ok;
    assign wready      = accept_ok;
    assign beat_accept = awvalid && wvalid && accept_ok;

    assign is_sume   = (awaddr.kind == sume_buffer);
    assign last_beat = is_sume && (sume_cnt_q == sume_cnt_width'(sume_word_count - 1));

    // only sume beats may continue a started entry
    assign beat_bad = !port_kind_ok(awaddr) || ((state_q == wr_collect) && !is_sume);

    // first beat ends up in the top word
    assign sume_next = {assembly_q[sume_width-axi_data_width-1:0], wdata};

    assign wr_req = '{kind:       wr_kind_q,
                      port_valid: wr_valid_q,
                      index:      wr_index_q,
                      value:      wr_value_q};

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            state_q    <= wr_idle;
            sume_cnt_q <= '0;
            wr_valid_q <= '0;
            bvalid     <= 1'b0;
        end
        else
        begin
            wr_valid_q <= '0;
            case (state_q)
                wr_idle, wr_collect:
                    if (beat_accept)
                    begin
                        if (beat_bad)
                        begin
                            // drop any partial sume entry
                            sume_cnt_q <= '0;
                            bvalid     <= 1'b1;
                            state_q    <= wr_respond;
                        end
                        else if (!is_sume || last_beat)
                        begin
                            wr_valid_q <= port_onehot(awaddr.port);
                            sume_cnt_q <= '0;
                            state_q    <= wr_await_ack;
                        end
                        else
                        begin
                            // intermediate sume word, answer at once
                            sume_cnt_q <= sume_cnt_q + 1'b1;
                            bvalid     <= 1'b1;
                            state_q    <= wr_respond;
                        end
                    end
                wr_await_ack:
                    if (wr_ack)
                    begin
                        bvalid  <= 1'b1;
                        state_q <= wr_respond;
                    end
                wr_respond:
                    if (bready)
                    begin
                        bvalid <= 1'b0;
                        if (sume_cnt_q != '0)
                            state_q <= wr_collect;
                        else
                            state_q <= wr_idle;
                    end
                default:
                    state_q <= wr_idle;
            endcase
        end
    end

    // assembly, request payload and b response code
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (beat_accept)
        begin
            wr_kind_q  <= awaddr.kind;
            wr_index_q <= awaddr.index;
            if (is_sume)
            begin
                assembly_q <= sume_next;
                wr_value_q <= sume_next;
            end
            else
            begin
                wr_value_q <= {{(sume_width-pifo_width){1'b0}}, wdata[pifo_width-1:0]};
            end
            bresp <= beat_bad ? resp_decerr : resp_okay;
        end
    end

    // tracks the buffer handshake as seen on the ports
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
            ack_pending_q <= 1'b0;
        else if (wr_req.port_valid != '0)
            ack_pending_q <= 1'b1;
        else if (wr_ack)
            ack_pending_q <= 1'b0;
    end

    // buffer request pulses for one cycle on a single port
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (wr_req.port_valid != '0) |->
            $onehot(wr_req.port_valid) && ($past(wr_req.port_valid) == '0));

    // no second write goes out before the buffer acknowledges the first
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (wr_req.port_valid != '0) |-> !ack_pending_q);

endmodule

// ==== source/sched_cpu_pkg.sv ====
package sched_cpu_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    // axi4-lite side
    localparam int axi_addr_width = 22;
    localparam int axi_data_width = 32;

    // scheduler side
    localparam int port_num     = 5;
    localparam int port_width   = 3;
    localparam int index_width  = 12;
    localparam int offset_width = 4;

    // one sume entry spans four bus words
    localparam int sume_word_count = 4;
    localparam int sume_cnt_width  = $clog2(sume_word_count);
    localparam int sume_width      = 128;
    localparam int pifo_width      = 32;

    // axi response codes in use
    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_decerr = 2'd3;

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////

    typedef enum logic [1:0]
    {
        pkt_buffer    = 2'd0,
        sume_buffer   = 2'd1,
        pifo_buffer   = 2'd2,
        pifo_calendar = 2'd3
    } buf_kind_e;

    // register address as seen on araddr / awaddr
    typedef struct packed
    {
        logic                    is_state;
        logic [port_width-1:0]   port;
        buf_kind_e               kind;
        logic [index_width-1:0]  index;
        logic [offset_width-1:0] offset;
    } cpu_addr_t;

    typedef struct packed
    {
        buf_kind_e              kind;
        logic [port_num-1:0]    port_valid;
        logic [index_width-1:0] index;
    } buf_rd_req_t;

    // pifo values sit in the low word
    typedef struct packed
    {
        logic                  valid;
        logic [sume_width-1:0] value;
    } buf_rd_resp_t;

    typedef struct packed
    {
        buf_kind_e              kind;
        logic [port_num-1:0]    port_valid;
        logic [index_width-1:0] index;
        logic [sume_width-1:0]  value;
    } buf_wr_req_t;

    //////////////////////////////////////////////////
    // decode helpers
    //////////////////////////////////////////////////

    // existing port and a buffer kind that is still served
    function automatic logic port_kind_ok(input cpu_addr_t addr);
        return (addr.port < port_num) && (addr.kind != pkt_buffer);
    endfunction

    function automatic logic [port_num-1:0] port_onehot(input logic [port_width-1:0] port);
        return port_num'(1) << port;
    endfunction

endpackage
